// ==== csr_trap_pkg.sv ====
package csr_trap_pkg;

    // Primary exception code width, as carried in ESTAT.Ecode
    localparam int ECODE_W = 6;

    // Secondary code width, as carried in ESTAT.EsubCode
    localparam int ESUBCODE_W = 9;

    // One trap event from the write-back stage
    // ex and ertn are single-cycle strobes and never arrive together
    typedef struct packed {
        // Exception entry strobe
        logic                  ex;
        // ERTN return strobe
        logic                  ertn;
        // PC of the instruction that raised the exception
        logic [31:0]           pc;
        // Primary code
        logic [ECODE_W-1:0]    ecode;
        // Secondary code
        logic [ESUBCODE_W-1:0] esubcode;
    } trap_evt_t;

endpackage

// ==== csr_map_pkg.sv ====
package csr_map_pkg;

    // Register number width
    localparam int CSR_NUM_W = 14;

    // Register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h0;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h1;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h4;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h5;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h6;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'hc;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h30;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE1  = 14'h31;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE2  = 14'h32;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE3  = 14'h33;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h44;

    // Interrupt status / enable vector width
    localparam int IRQ_W = 13;

    // Bit 10 and bit 12 (former IPI) are reserved
    localparam logic [IRQ_W-1:0] LIE_WRITABLE = 13'h0bff;

    // Counter parks here once a one-shot count has expired
    localparam logic [31:0] TIMER_IDLE = 32'hffff_ffff;

    // Field layouts, MSB first
    typedef struct packed {
        logic [28:0] rsvd;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] rsvd;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic [18:0]      rsvd;
        logic [IRQ_W-1:0] lie;
    } ecfg_t;

    typedef struct packed {
        logic                                rsvd_hi;
        logic [csr_trap_pkg::ESUBCODE_W-1:0] esubcode;
        logic [csr_trap_pkg::ECODE_W-1:0]    ecode;
        logic [2:0]                          rsvd_lo;
        logic [IRQ_W-1:0]                    is;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // Entry base is 64-byte aligned
    typedef struct packed {
        logic [25:0] va;
        logic [5:0]  rsvd;
    } eentry_t;

    typedef struct packed {
        logic [30:0] rsvd;
        logic        clr;
    } ticlr_t;

    // One 32-bit word, seen through each register's layout
    typedef union packed {
        logic [31:0] raw;
        crmd_t       crmd;
        prmd_t       prmd;
        ecfg_t       ecfg;
        estat_t      estat;
        tcfg_t       tcfg;
        eentry_t     eentry;
        ticlr_t      ticlr;
    } csr_word_u;

    // Masked write request from the CPU
    typedef struct packed {
        logic                 en;
        logic [CSR_NUM_W-1:0] num;
        csr_word_u            mask;
        csr_word_u            value;
    } csr_wr_t;

    // New bits under the mask, old bits elsewhere
    function automatic csr_word_u masked_merge(input csr_wr_t wr, input logic [31:0] old_word);
        csr_word_u merged;
        merged.raw = (wr.mask.raw & wr.value.raw) | (~wr.mask.raw & old_word);
        return merged;
    endfunction

endpackage

// ==== csr_mode_ctrl.sv ====
module csr_mode_ctrl (
    input  logic                                clk,
    input  logic                                reset,
    input  csr_map_pkg::csr_wr_t                wr,
    input  csr_trap_pkg::trap_evt_t             trap,
    input  logic [csr_map_pkg::CSR_NUM_W-1:0]   rd_num,
    output logic [31:0]                         rd_part,
    output logic [31:0]                         ertn_pc,
    output logic [31:0]                         ex_entry,
    output logic                                global_ie
);

    // Current and saved mode
    logic [1:0] plv;
    logic       ie;
    logic [1:0] pplv;
    logic       pie;
    // Return address and recorded codes
    logic [31:0]                           era;
    logic [csr_trap_pkg::ECODE_W-1:0]      ecode;
    logic [csr_trap_pkg::ESUBCODE_W-1:0]   esubcode;
    // Exception entry base
    logic [25:0] eentry_va;

    csr_map_pkg::csr_word_u crmd_cur;
    csr_map_pkg::csr_word_u prmd_cur;
    csr_map_pkg::csr_word_u eentry_cur;
    csr_map_pkg::csr_word_u crmd_new;
    csr_map_pkg::csr_word_u prmd_new;
    csr_map_pkg::csr_word_u era_new;
    csr_map_pkg::csr_word_u eentry_new;
    csr_map_pkg::csr_word_u rd_word;

    // Register views, reserved bits read zero
    always_comb
    begin
        crmd_cur.raw        = '0;
        crmd_cur.crmd.plv   = plv;
        crmd_cur.crmd.ie    = ie;
        prmd_cur.raw        = '0;
        prmd_cur.prmd.pplv  = pplv;
        prmd_cur.prmd.pie   = pie;
        eentry_cur.raw      = '0;
        eentry_cur.eentry.va = eentry_va;
    end

    // Candidate values for a masked write
    assign crmd_new   = csr_map_pkg::masked_merge(wr, crmd_cur.raw);
    assign prmd_new   = csr_map_pkg::masked_merge(wr, prmd_cur.raw);
    assign era_new    = csr_map_pkg::masked_merge(wr, era);
    assign eentry_new = csr_map_pkg::masked_merge(wr, eentry_cur.raw);

    // CRMD: exception, then ERTN, then software write
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            plv <= 2'b00;
            ie  <= 1'b0;
        end
        else if (trap.ex)
        begin
            // Enter kernel mode with interrupts masked
            plv <= 2'b00;
            ie  <= 1'b0;
        end
        else if (trap.ertn)
        begin
            plv <= pplv;
            ie  <= pie;
        end
        else if (wr.en && wr.num == csr_map_pkg::CSR_CRMD)
        begin
            plv <= crmd_new.crmd.plv;
            ie  <= crmd_new.crmd.ie;
        end
    end

    // PRMD, ERA, codes and EENTRY
    always_ff @(posedge clk)
    begin
        if (trap.ex)
        begin
            // Save the interrupted mode
            pplv     <= plv;
            pie      <= ie;
            era      <= trap.pc;
            ecode    <= trap.ecode;
            esubcode <= trap.esubcode;
        end
        else
        begin
            if (wr.en && wr.num == csr_map_pkg::CSR_PRMD)
            begin
                pplv <= prmd_new.prmd.pplv;
                pie  <= prmd_new.prmd.pie;
            end
            if (wr.en && wr.num == csr_map_pkg::CSR_ERA)
                era <= era_new.raw;
        end
        // Only software touches the entry base
        if (wr.en && wr.num == csr_map_pkg::CSR_EENTRY)
            eentry_va <= eentry_new.eentry.va;
    end

    // Read mux; ESTAT carries only the code fields here
    always_comb
    begin
        rd_word.raw = '0;
        case (rd_num)
            csr_map_pkg::CSR_CRMD:   rd_word = crmd_cur;
            csr_map_pkg::CSR_PRMD:   rd_word = prmd_cur;
            csr_map_pkg::CSR_ERA:    rd_word.raw = era;
            csr_map_pkg::CSR_EENTRY: rd_word = eentry_cur;
            csr_map_pkg::CSR_ESTAT:
            begin
                rd_word.estat.ecode    = ecode;
                rd_word.estat.esubcode = esubcode;
            end
            default:                 rd_word.raw = '0;
        endcase
    end

    assign rd_part   = rd_word.raw;
    assign ertn_pc   = era;
    assign ex_entry  = eentry_cur.raw;
    assign global_ie = ie;

    // The pipeline never flushes with both strobes in one cycle
    a_trap_onehot: assert property (@(posedge clk) disable iff (reset)
        !(trap.ex && trap.ertn));

endmodule

// ==== csr_irq_status.sv ====
module csr_irq_status (
    input  logic                               clk,
    input  logic                               reset,
    input  csr_map_pkg::csr_wr_t               wr,
    input  logic [csr_map_pkg::CSR_NUM_W-1:0]  rd_num,
    input  logic [7:0]                         hw_int,
    input  logic                               timer_hit,
    input  logic                               global_ie,
    output logic [31:0]                        rd_part,
    output logic                               has_int
);

    // Local enables
    logic [csr_map_pkg::IRQ_W-1:0] lie;
    // Software interrupt bits SWI0/SWI1
    logic [1:0] swi;
    // Sampled hardware lines HWI0..HWI7
    logic [7:0] hwi;
    // Assembled IS vector
    logic [csr_map_pkg::IRQ_W-1:0] is_vec;

    csr_map_pkg::csr_word_u ecfg_cur;
    csr_map_pkg::csr_word_u estat_cur;
    csr_map_pkg::csr_word_u ecfg_new;
    csr_map_pkg::csr_word_u estat_new;

    // Bit 12 and bit 10 reserved, bit 11 is the timer
    assign is_vec = {1'b0, timer_hit, 1'b0, hwi, swi};

    always_comb
    begin
        ecfg_cur.raw       = '0;
        ecfg_cur.ecfg.lie  = lie;
        estat_cur.raw      = '0;
        estat_cur.estat.is = is_vec;
    end

    assign ecfg_new  = csr_map_pkg::masked_merge(wr, ecfg_cur.raw);
    assign estat_new = csr_map_pkg::masked_merge(wr, estat_cur.raw);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            lie <= '0;
            swi <= 2'b00;
            hwi <= 8'h00;
        end
        else
        begin
            // Reserved enables can never be set
            if (wr.en && wr.num == csr_map_pkg::CSR_ECFG)
                lie <= ecfg_new.ecfg.lie & csr_map_pkg::LIE_WRITABLE;
            // Only the software bits of IS are writable
            if (wr.en && wr.num == csr_map_pkg::CSR_ESTAT)
                swi <= estat_new.estat.is[1:0];
            hwi <= hw_int;
        end
    end

    // Low half of ESTAT only, codes come from the mode group
    always_comb
    begin
        case (rd_num)
            csr_map_pkg::CSR_ECFG:  rd_part = ecfg_cur.raw;
            csr_map_pkg::CSR_ESTAT: rd_part = estat_cur.raw;
            default:                rd_part = '0;
        endcase
    end

    // Any enabled pending source, gated by CRMD.IE
    assign has_int = (|(is_vec & lie)) && global_ie;

    a_lie_rsvd: assert property (@(posedge clk) disable iff (reset)
        (lie & ~csr_map_pkg::LIE_WRITABLE) == '0);

endmodule

// ==== csr_timer.sv ====
module csr_timer (
    input  logic                               clk,
    input  logic                               reset,
    input  csr_map_pkg::csr_wr_t               wr,
    input  logic [csr_map_pkg::CSR_NUM_W-1:0]  rd_num,
    output logic [31:0]                        rd_part,
    output logic                               timer_hit
);

    // TCFG fields
    logic        en;
    logic        periodic;
    logic [29:0] initval;
    // Down counter, read back as TVAL
    logic [31:0] cnt;
    // Timer interrupt flag, ESTAT.IS[11]
    logic        flag;

    logic tcfg_we;
    logic tcfg_start;
    logic ticlr_hit;

    csr_map_pkg::csr_word_u tcfg_cur;
    csr_map_pkg::csr_word_u tcfg_new;

    always_comb
    begin
        tcfg_cur.raw           = '0;
        tcfg_cur.tcfg.en       = en;
        tcfg_cur.tcfg.periodic = periodic;
        tcfg_cur.tcfg.initval  = initval;
    end

    // Merged TCFG is what the counter acts on in the write cycle
    assign tcfg_new   = csr_map_pkg::masked_merge(wr, tcfg_cur.raw);
    assign tcfg_we    = wr.en && wr.num == csr_map_pkg::CSR_TCFG;
    assign tcfg_start = tcfg_we && tcfg_new.tcfg.en;
    // CLR is write-one; a masked-off or zero write does nothing
    assign ticlr_hit  = wr.en && wr.num == csr_map_pkg::CSR_TICLR
                        && wr.mask.ticlr.clr && wr.value.ticlr.clr;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            en       <= 1'b0;
            periodic <= 1'b0;
            initval  <= '0;
            cnt      <= csr_map_pkg::TIMER_IDLE;
            flag     <= 1'b0;
        end
        else
        begin
            if (tcfg_we)
            begin
                en       <= tcfg_new.tcfg.en;
                periodic <= tcfg_new.tcfg.periodic;
                initval  <= tcfg_new.tcfg.initval;
            end
            // Enabling write wins over counting
            if (tcfg_start)
                cnt <= {tcfg_new.tcfg.initval, 2'b00};
            else if (en && cnt != csr_map_pkg::TIMER_IDLE)
            begin
                // Reload in periodic mode, else wrap to idle and stop
                if (cnt == '0 && periodic)
                    cnt <= {initval, 2'b00};
                else
                    cnt <= cnt - 32'd1;
            end
            // Set beats clear
            if (en && cnt == '0)
                flag <= 1'b1;
            else if (ticlr_hit)
                flag <= 1'b0;
        end
    end

    // TICLR falls into the default and reads zero
    always_comb
    begin
        case (rd_num)
            csr_map_pkg::CSR_TCFG: rd_part = tcfg_cur.raw;
            csr_map_pkg::CSR_TVAL: rd_part = cnt;
            default:               rd_part = '0;
        endcase
    end

    assign timer_hit = flag;

    // Idle counter only restarts through an enabling TCFG write
    a_idle_hold: assert property (@(posedge clk) disable iff (reset)
        (!en && cnt == csr_map_pkg::TIMER_IDLE && !tcfg_start)
        |=> cnt == csr_map_pkg::TIMER_IDLE);

endmodule

// ==== csr_save_regs.sv ====
module csr_save_regs (
    input  logic                               clk,
    input  csr_map_pkg::csr_wr_t               wr,
    input  logic [csr_map_pkg::CSR_NUM_W-1:0]  rd_num,
    output logic [31:0]                        rd_part
);

    // SAVE0..SAVE3, indexed by the low two bits of the number
    logic [31:0] save_mem [4];

    logic wr_hit;
    logic rd_hit;

    csr_map_pkg::csr_word_u save_new;

    // SAVE0..3 share every bit above the low two
    assign wr_hit = wr.en && wr.num[csr_map_pkg::CSR_NUM_W-1:2]
                    == csr_map_pkg::CSR_SAVE0[csr_map_pkg::CSR_NUM_W-1:2];
    assign rd_hit = rd_num[csr_map_pkg::CSR_NUM_W-1:2]
                    == csr_map_pkg::CSR_SAVE0[csr_map_pkg::CSR_NUM_W-1:2];

    // Merge against the addressed word
    assign save_new = csr_map_pkg::masked_merge(wr, save_mem[wr.num[1:0]]);

    always_ff @(posedge clk)
    begin
        if (wr_hit)
            save_mem[wr.num[1:0]] <= save_new.raw;
    end

    assign rd_part = rd_hit ? save_mem[rd_num[1:0]] : 32'h0;

endmodule

// ==== csr_file.sv ====
module csr_file (
    input  logic                               clk,
    input  logic                               reset,
    input  csr_map_pkg::csr_wr_t               wr,
    input  csr_trap_pkg::trap_evt_t            trap,
    input  logic [csr_map_pkg::CSR_NUM_W-1:0]  rd_num,
    input  logic [7:0]                         hw_int,
    output logic [31:0]                        rdata,
    output logic [31:0]                        ertn_pc,
    output logic [31:0]                        ex_entry,
    output logic                               has_int
);

    // Per-group read contributions, zero when not addressed
    logic [31:0] rd_mode;
    logic [31:0] rd_irq;
    logic [31:0] rd_timer;
    logic [31:0] rd_save;

    // Cross-group status
    logic global_ie;
    logic timer_hit;

    // Mode, return address, codes and entry base
    csr_mode_ctrl i_mode_ctrl (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .trap      (trap),
        .rd_num    (rd_num),
        .rd_part   (rd_mode),
        .ertn_pc   (ertn_pc),
        .ex_entry  (ex_entry),
        .global_ie (global_ie)
    );

    // Interrupt pending, enables and request
    csr_irq_status i_irq_status (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rd_num    (rd_num),
        .hw_int    (hw_int),
        .timer_hit (timer_hit),
        .global_ie (global_ie),
        .rd_part   (rd_irq),
        .has_int   (has_int)
    );

    csr_timer i_timer (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr),
        .rd_num    (rd_num),
        .rd_part   (rd_timer),
        .timer_hit (timer_hit)
    );

    // Scratch words
    csr_save_regs i_save_regs (
        .clk     (clk),
        .wr      (wr),
        .rd_num  (rd_num),
        .rd_part (rd_save)
    );

    // ESTAT gets its codes from one group and IS from another
    assign rdata = rd_mode | rd_irq | rd_timer | rd_save;

endmodule

// ==== csr_checker.sv ====
module csr_checker (
    input  logic                               clk,
    input  logic                               check_en,
    input  logic [csr_map_pkg::CSR_NUM_W-1:0]  rd_num,
    input  logic [31:0]                        exp_rdata,
    input  logic [31:0]                        exp_ertn_pc,
    input  logic [31:0]                        exp_ex_entry,
    input  logic                               exp_has_int,
    input  logic [31:0]                        rdata,
    input  logic [31:0]                        ertn_pc,
    input  logic [31:0]                        ex_entry,
    input  logic                               has_int,
    output int                                 errors
);

    // Mismatches seen so far
    int err_count = 0;

    // One line per wrong value
    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected)
        begin
            err_count++;
            $display("FAIL time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    // Inputs change on the falling edge, so values here are settled
    always @(posedge clk)
    begin
        if (check_en)
        begin
            compare($sformatf("rdata[%h]", rd_num), exp_rdata, rdata);
            compare("ertn_pc", exp_ertn_pc, ertn_pc);
            compare("ex_entry", exp_ex_entry, ex_entry);
            compare("has_int", {31'h0, exp_has_int}, {31'h0, has_int});
        end
    end

    assign errors = err_count;

endmodule

// ==== tb_csr_file.sv ====
module tb_csr_file;

    // Cycles per test, summed for the watchdog
    localparam int RESET_CYCLES = 10;
    localparam int INIT_CYCLES  = 12;
    localparam int WR_CYCLES    = 300;
    localparam int TRAP_ROUNDS  = 8;
    localparam int PRIO_CYCLES  = 12;
    localparam int TIMER_CYCLES = 80;
    localparam int IRQ_CYCLES   = 200;
    localparam int MARGIN       = 100;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + INIT_CYCLES + WR_CYCLES + TRAP_ROUNDS * 7
                                     + PRIO_CYCLES + 2 * TIMER_CYCLES + IRQ_CYCLES + MARGIN;

    logic clk = 1'b0;
    logic reset;
    csr_map_pkg::csr_wr_t wr;
    csr_trap_pkg::trap_evt_t trap;
    logic [csr_map_pkg::CSR_NUM_W-1:0] rd_num;
    logic [7:0] hw_int;
    logic [31:0] rdata;
    logic [31:0] ertn_pc;
    logic [31:0] ex_entry;
    logic has_int;

    // Staged inputs, put on the DUT at the next falling edge
    logic s_reset;
    csr_map_pkg::csr_wr_t s_wr;
    csr_trap_pkg::trap_evt_t s_trap;
    logic [csr_map_pkg::CSR_NUM_W-1:0] s_num;
    logic [7:0] s_hw;

    // Expected outputs for the checker
    logic [31:0] exp_rdata;
    logic [31:0] exp_ertn_pc;
    logic [31:0] exp_ex_entry;
    logic exp_has_int;
    logic check_en;
    int errors;

    // Register model
    logic [1:0] m_plv;
    logic [1:0] m_pplv;
    logic m_ie;
    logic m_pie;
    logic [31:0] m_era;
    logic [31:0] m_eentry;
    logic [5:0] m_ecode;
    logic [8:0] m_esub;
    logic [12:0] m_lie;
    logic [1:0] m_swi;
    logic [7:0] m_hwi;
    logic m_en;
    logic m_periodic;
    logic m_flag;
    logic [29:0] m_initval;
    logic [31:0] m_cnt;
    logic [31:0] m_save [4];

    integer seed;
    logic [29:0] iv;
    string test_name;
    int test_err0;
    int test_count;
    int failed_tests;

    always #5 clk = ~clk;

    csr_file i_csr_file (
        .clk      (clk),
        .reset    (reset),
        .wr       (wr),
        .trap     (trap),
        .rd_num   (rd_num),
        .hw_int   (hw_int),
        .rdata    (rdata),
        .ertn_pc  (ertn_pc),
        .ex_entry (ex_entry),
        .has_int  (has_int)
    );

    csr_checker i_checker (
        .clk          (clk),
        .check_en     (check_en),
        .rd_num       (rd_num),
        .exp_rdata    (exp_rdata),
        .exp_ertn_pc  (exp_ertn_pc),
        .exp_ex_entry (exp_ex_entry),
        .exp_has_int  (exp_has_int),
        .rdata        (rdata),
        .ertn_pc      (ertn_pc),
        .ex_entry     (ex_entry),
        .has_int      (has_int),
        .errors       (errors)
    );

    // New bits under the mask, old bits elsewhere
    function automatic logic [31:0] merge_bits(input logic [31:0] old_word);
        return (wr.mask.raw & wr.value.raw) | (~wr.mask.raw & old_word);
    endfunction

    function automatic logic write_to(input logic [csr_map_pkg::CSR_NUM_W-1:0] num);
        return wr.en && wr.num == num;
    endfunction

    // IS vector: timer at 11, bits 10 and 12 reserved
    function automatic logic [12:0] pending_bits();
        return {1'b0, m_flag, 1'b0, m_hwi, m_swi};
    endfunction

    // Expected read value of one register number
    function automatic logic [31:0] expected_read(input logic [csr_map_pkg::CSR_NUM_W-1:0] num);
        case (num)
            csr_map_pkg::CSR_CRMD:   return {29'h0, m_ie, m_plv};
            csr_map_pkg::CSR_PRMD:   return {29'h0, m_pie, m_pplv};
            csr_map_pkg::CSR_ECFG:   return {19'h0, m_lie};
            csr_map_pkg::CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'b000, pending_bits()};
            csr_map_pkg::CSR_ERA:    return m_era;
            csr_map_pkg::CSR_EENTRY: return m_eentry;
            csr_map_pkg::CSR_SAVE0,
            csr_map_pkg::CSR_SAVE1,
            csr_map_pkg::CSR_SAVE2,
            csr_map_pkg::CSR_SAVE3:  return m_save[num[1:0]];
            csr_map_pkg::CSR_TCFG:   return {m_initval, m_periodic, m_en};
            csr_map_pkg::CSR_TVAL:   return m_cnt;
            default:                 return 32'h0;
        endcase
    endfunction

    // Register numbers for random picks; the first eight are written
    function automatic logic [csr_map_pkg::CSR_NUM_W-1:0] reg_at(input int i);
        case (i)
            0:       return csr_map_pkg::CSR_SAVE0;
            1:       return csr_map_pkg::CSR_SAVE1;
            2:       return csr_map_pkg::CSR_SAVE2;
            3:       return csr_map_pkg::CSR_SAVE3;
            4:       return csr_map_pkg::CSR_EENTRY;
            5:       return csr_map_pkg::CSR_ECFG;
            6:       return csr_map_pkg::CSR_CRMD;
            7:       return csr_map_pkg::CSR_PRMD;
            8:       return csr_map_pkg::CSR_ESTAT;
            9:       return csr_map_pkg::CSR_ERA;
            10:      return csr_map_pkg::CSR_TCFG;
            11:      return csr_map_pkg::CSR_TVAL;
            12:      return csr_map_pkg::CSR_TICLR;
            default: return 14'h2a5;
        endcase
    endfunction

    // One rising edge of the model, with the inputs held across it
    task automatic model_edge();
        logic [31:0] w;
        if (reset)
        begin
            m_plv = 2'b00;
            m_ie = 1'b0;
            m_lie = '0;
            m_swi = 2'b00;
            m_hwi = 8'h00;
            m_en = 1'b0;
            m_periodic = 1'b0;
            m_initval = '0;
            m_cnt = 32'hffff_ffff;
            m_flag = 1'b0;
        end
        else
        begin
            // Exception first, then ERTN, then software writes
            if (trap.ex)
            begin
                m_pplv = m_plv;
                m_pie = m_ie;
                m_plv = 2'b00;
                m_ie = 1'b0;
                m_era = trap.pc;
                m_ecode = trap.ecode;
                m_esub = trap.esubcode;
            end
            else
            begin
                w = merge_bits({29'h0, m_ie, m_plv});
                // ERTN takes the saved mode from before this edge
                if (trap.ertn)
                begin
                    m_plv = m_pplv;
                    m_ie = m_pie;
                end
                else if (write_to(csr_map_pkg::CSR_CRMD))
                begin
                    m_plv = w[1:0];
                    m_ie = w[2];
                end
                w = merge_bits({29'h0, m_pie, m_pplv});
                if (write_to(csr_map_pkg::CSR_PRMD))
                begin
                    m_pplv = w[1:0];
                    m_pie = w[2];
                end
                if (write_to(csr_map_pkg::CSR_ERA))
                    m_era = merge_bits(m_era);
            end
            // Entry base is 64-byte aligned
            if (write_to(csr_map_pkg::CSR_EENTRY))
                m_eentry = merge_bits(m_eentry) & 32'hffff_ffc0;
            w = merge_bits({19'h0, m_lie});
            if (write_to(csr_map_pkg::CSR_ECFG))
                m_lie = w[12:0] & 13'h0bff;
            w = merge_bits({30'h0, m_swi});
            if (write_to(csr_map_pkg::CSR_ESTAT))
                m_swi = w[1:0];
            if (wr.en && wr.num[13:2] == 12'h00c)
                m_save[wr.num[1:0]] = merge_bits(m_save[wr.num[1:0]]);
            m_hwi = hw_int;
            // Flag looks at the count before this edge; set beats clear
            if (m_en && m_cnt == 32'h0)
                m_flag = 1'b1;
            else if (write_to(csr_map_pkg::CSR_TICLR) && wr.mask.raw[0] && wr.value.raw[0])
                m_flag = 1'b0;
            w = merge_bits({m_initval, m_periodic, m_en});
            if (write_to(csr_map_pkg::CSR_TCFG) && w[0])
                m_cnt = {w[31:2], 2'b00};
            else if (m_en && m_cnt != 32'hffff_ffff)
                m_cnt = (m_cnt == 32'h0 && m_periodic) ? {m_initval, 2'b00} : m_cnt - 32'd1;
            if (write_to(csr_map_pkg::CSR_TCFG))
            begin
                m_initval = w[31:2];
                m_periodic = w[1];
                m_en = w[0];
            end
        end
    endtask

    // Advance one cycle: model the last edge, drive, recompute expected
    task automatic cycle();
        @(negedge clk);
        model_edge();
        reset = s_reset;
        wr = s_wr;
        trap = s_trap;
        rd_num = s_num;
        hw_int = s_hw;
        // Strobes last a single cycle
        s_wr.en = 1'b0;
        s_trap.ex = 1'b0;
        s_trap.ertn = 1'b0;
        exp_rdata = expected_read(s_num);
        exp_ertn_pc = m_era;
        exp_ex_entry = m_eentry;
        exp_has_int = (|(pending_bits() & m_lie)) && m_ie;
    endtask

    task automatic queue_write(input logic [csr_map_pkg::CSR_NUM_W-1:0] num,
                               input logic [31:0] mask, input logic [31:0] value);
        s_wr.en = 1'b1;
        s_wr.num = num;
        s_wr.mask.raw = mask;
        s_wr.value.raw = value;
    endtask

    task automatic write_reg(input logic [csr_map_pkg::CSR_NUM_W-1:0] num,
                             input logic [31:0] mask, input logic [31:0] value);
        queue_write(num, mask, value);
        cycle();
    endtask

    task automatic open_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    // One more cycle lets the checker see the last stimulus
    task automatic close_test();
        int bad;
        cycle();
        bad = errors - test_err0;
        test_count++;
        if (bad != 0)
            failed_tests++;
        $display("%s: %s, %0d mismatches", test_name, (bad == 0) ? "passed" : "failed", bad);
    endtask

    // Watchdog
    initial
    begin
        #(WATCHDOG_CYCLES * 10);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        seed = 58241;
        reset = 1'b1;
        wr = '0;
        trap = '0;
        rd_num = '0;
        hw_int = 8'h00;
        s_reset = 1'b1;
        s_wr = '0;
        s_trap = '0;
        s_num = csr_map_pkg::CSR_CRMD;
        s_hw = 8'h00;
        check_en = 1'b0;
        test_count = 0;
        failed_tests = 0;
        repeat (RESET_CYCLES) cycle();
        s_reset = 1'b0;

        // Give the unreset registers known values
        s_trap.ex = 1'b1;
        cycle();
        write_reg(csr_map_pkg::CSR_PRMD, 32'hffff_ffff, 32'h0);
        write_reg(csr_map_pkg::CSR_ERA, 32'hffff_ffff, 32'h0);
        write_reg(csr_map_pkg::CSR_EENTRY, 32'hffff_ffff, 32'h0);
        for (int i = 0; i < 4; i++)
            write_reg(reg_at(i), 32'hffff_ffff, 32'h0);
        cycle();
        check_en = 1'b1;

        open_test("masked_writes");
        repeat (WR_CYCLES)
        begin
            s_num = reg_at($unsigned($random(seed)) % 14);
            if ($random(seed) & 1)
                queue_write(reg_at($unsigned($random(seed)) % 8), $random(seed), $random(seed));
            cycle();
        end
        close_test();

        open_test("trap_entry_return");
        repeat (TRAP_ROUNDS)
        begin
            s_num = csr_map_pkg::CSR_CRMD;
            write_reg(csr_map_pkg::CSR_CRMD, 32'h7, $random(seed));
            s_trap.pc = $random(seed);
            s_trap.ecode = 6'($random(seed));
            s_trap.esubcode = 9'($random(seed));
            s_trap.ex = 1'b1;
            cycle();
            // Kernel mode with interrupts off
            cycle();
            s_num = csr_map_pkg::CSR_PRMD;
            cycle();
            s_num = csr_map_pkg::CSR_ERA;
            cycle();
            s_num = csr_map_pkg::CSR_ESTAT;
            s_trap.ertn = 1'b1;
            cycle();
            s_num = csr_map_pkg::CSR_CRMD;
            cycle();
        end
        close_test();

        open_test("priority");
        s_num = csr_map_pkg::CSR_CRMD;
        write_reg(csr_map_pkg::CSR_CRMD, 32'h7, 32'h7);
        queue_write(csr_map_pkg::CSR_CRMD, 32'h7, 32'h5);
        s_trap.pc = $random(seed);
        s_trap.ex = 1'b1;
        cycle();
        // CRMD after the exception that met a write
        cycle();
        s_num = csr_map_pkg::CSR_ERA;
        queue_write(csr_map_pkg::CSR_ERA, 32'hffff_ffff, 32'h1234_5678);
        s_trap.pc = $random(seed);
        s_trap.ex = 1'b1;
        cycle();
        write_reg(csr_map_pkg::CSR_PRMD, 32'h7, 32'h7);
        s_num = csr_map_pkg::CSR_CRMD;
        queue_write(csr_map_pkg::CSR_CRMD, 32'h7, 32'h0);
        s_trap.ertn = 1'b1;
        cycle();
        close_test();

        // Timer interrupt enabled so has_int follows the flag
        open_test("oneshot_timer");
        iv = 30'(2 + $unsigned($random(seed)) % 8);
        write_reg(csr_map_pkg::CSR_CRMD, 32'h4, 32'h4);
        write_reg(csr_map_pkg::CSR_ECFG, 32'h1fff, 32'h800);
        s_num = csr_map_pkg::CSR_TVAL;
        write_reg(csr_map_pkg::CSR_TCFG, 32'hffff_ffff, {iv, 2'b01});
        repeat (iv * 4 + 3) cycle();
        s_num = csr_map_pkg::CSR_ESTAT;
        cycle();
        write_reg(csr_map_pkg::CSR_TICLR, 32'h1, 32'h1);
        cycle();
        close_test();

        open_test("periodic_timer");
        iv = 30'(1 + $unsigned($random(seed)) % 4);
        s_num = csr_map_pkg::CSR_TVAL;
        write_reg(csr_map_pkg::CSR_TCFG, 32'hffff_ffff, {iv, 2'b11});
        repeat (3 * (iv * 4 + 1) + 2)
        begin
            if (m_flag)
                queue_write(csr_map_pkg::CSR_TICLR, 32'h1, 32'h1);
            cycle();
        end
        write_reg(csr_map_pkg::CSR_TCFG, 32'hffff_ffff, 32'h0);
        close_test();

        open_test("irq_request");
        s_num = csr_map_pkg::CSR_ESTAT;
        repeat (IRQ_CYCLES)
        begin
            s_hw = 8'($random(seed));
            case ($unsigned($random(seed)) % 4)
                0:       queue_write(csr_map_pkg::CSR_ECFG, 32'h1fff, $random(seed));
                1:       queue_write(csr_map_pkg::CSR_ESTAT, 32'h3, $random(seed));
                2:       queue_write(csr_map_pkg::CSR_CRMD, 32'h4, $random(seed));
                default: ;
            endcase
            cycle();
        end
        s_hw = 8'h00;
        close_test();

        $display("Summary: %0d tests, %0d failed, %0d mismatches",
                 test_count, failed_tests, errors);
        if (errors == 0 && failed_tests == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
csr_trap_pkg.sv
csr_map_pkg.sv
csr_mode_ctrl.sv
csr_irq_status.sv
csr_timer.sv
csr_save_regs.sv
csr_file.sv
csr_checker.sv
tb_csr_file.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_csr_file -f sim.f -Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
grep -q "^Test OK$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
